/* build.f */
+incdir+src
src/busPkg.sv
src/csrPkg.sv
src/microControllerCsr.sv
src/busReadCapture.sv
src/regFileSlave.sv
src/accumulatorSlave.sv
src/microControllerBlock.sv
testbench/microControllerBlockTb.sv

/* testbench/microControllerBlockTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcbBus_defs.svh"

module microControllerBlockTb;

	// Test lengths set the cycle limit
	localparam int lpRegOps = 200;
	localparam int lpAccOps = 40;
	localparam int lpCycleLimit = (lpRegOps + lpAccOps + 20) * 20;

	logic sysClk;
	logic reset;
	csrPkg::csrData_t csrWd;
	csrPkg::csrAdrs_t csrAdrs;
	logic csrCke;
	csrPkg::csrData_t csrRd;
	busPkg::busData_t autoRd;
	busPkg::slaveMask_t readEd;

	// ----------------------------------------
	// Reference model state
	// ----------------------------------------
	busPkg::busData_t regModel [4];
	busPkg::busData_t accSum;
	busPkg::busData_t accCount;
	// Last slave that replied
	busPkg::slaveIdx_t lastIdx;
	logic [31:0] lcgState;
	int cycleCount = 0;

	microControllerBlock dut_i (
		.sysClk (sysClk),
		.reset (reset),
		.csrWd (csrWd),
		.csrAdrs (csrAdrs),
		.csrCke (csrCke),
		.csrRd (csrRd),
		.autoRd (autoRd),
		.readEd (readEd)
	);

	// 20 ns clock
	initial
	begin
		sysClk = 1'b0;
		forever #10 sysClk = ~sysClk;
	end

	// Numerical Recipes LCG constants
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Slave select in bits 14 to 12 with the offset below and the command bit clear
	function automatic csrPkg::csrData_t makeBusAdrs(input int idx, input int ofs);
		return csrPkg::csrData_t'((idx << `MCB_SLAVE_LSB) | ofs);
	endfunction

	// Expected status word with busy clear
	function automatic csrPkg::csrData_t expStatus(input logic tmo);
		csrPkg::csrData_t st;
		st = '0;
		st[1] = tmo;
		st[6:4] = lastIdx;
		return st;
	endfunction

	// ----------------------------------------
	// Error handling and compares
	// ----------------------------------------
	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkData(input string name, input busPkg::busData_t got,
		input busPkg::busData_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic checkMask(input string name, input busPkg::slaveMask_t got,
		input busPkg::slaveMask_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic checkStatus(input string name, input csrPkg::csrData_t got,
		input csrPkg::csrData_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// Cycle budget
	always @(posedge sysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= lpCycleLimit)
			stopOnError($sformatf("simulation did not finish within %0d cycles", lpCycleLimit));
	end

	// ----------------------------------------
	// Host tasks entered just after a rising edge
	// ----------------------------------------

	// One cycle of cke
	task automatic csrWrite(input csrPkg::csrAdrs_t adrs, input csrPkg::csrData_t data);
		csrAdrs <= adrs;
		csrWd <= data;
		csrCke <= 1'b1;
		@(posedge sysClk);
		csrCke <= 1'b0;
	endtask

	// Registered read-back sampled on the falling edge after
	task automatic csrRead(input csrPkg::csrAdrs_t adrs, output csrPkg::csrData_t value);
		csrAdrs <= adrs;
		csrCke <= 1'b0;
		@(posedge sysClk);
		@(negedge sysClk);
		value = csrRd;
		@(posedge sysClk);
	endtask

	task automatic waitNotBusy();
		csrPkg::csrData_t st;
		st = 32'h1;
		while (st[0])
			csrRead(csrPkg::CSR_STATUS, st);
	endtask

	task automatic busOp(input csrPkg::csrData_t adrs, input csrPkg::csrData_t wd,
		input csrPkg::csrData_t cmd);
		csrWrite(csrPkg::CSR_BUS_ADRS, adrs);
		csrWrite(csrPkg::CSR_BUS_WD, wd);
		csrWrite(csrPkg::CSR_CMD, cmd);
		waitNotBusy();
	endtask

	task automatic busWrite(input int idx, input int ofs, input busPkg::busData_t data);
		busOp(makeBusAdrs(idx, ofs), data, 32'h1);
	endtask

	// Bus read then auto result, mask and status against the model
	task automatic readAndCheck(input int idx, input int ofs, input busPkg::busData_t exp);
		csrPkg::csrData_t word;
		busPkg::slaveMask_t expMask;
		expMask = busPkg::slaveMask_t'(1) << idx;
		busOp(makeBusAdrs(idx, ofs), '0, 32'h2);
		lastIdx = busPkg::slaveIdx_t'(idx);
		@(negedge sysClk);
		checkData("autoRd", autoRd, exp);
		checkMask("readEd", readEd, expMask);
		@(posedge sysClk);
		csrRead(csrPkg::CSR_AUTO_RD, word);
		checkData("csrRd(CSR_AUTO_RD)", word, exp);
		csrRead(csrPkg::CSR_STATUS, word);
		checkStatus("csrRd(CSR_STATUS)", word, expStatus(1'b0));
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		busPkg::busData_t data;
		csrPkg::csrData_t word;
		csrPkg::csrAdrs_t csrList [5];
		int ofs;
		int pick;
		reset = 1'b1;
		csrWd = '0;
		csrAdrs = '0;
		csrCke = 1'b0;
		lcgState = 32'd54;
		accSum = '0;
		accCount = '0;
		lastIdx = '0;
		for (int i = 0; i < 4; i++)
			regModel[i] = '0;
		csrList = '{csrPkg::CSR_BUS_ADRS, csrPkg::CSR_BUS_WD, csrPkg::CSR_CMD,
			csrPkg::CSR_STATUS, csrPkg::CSR_AUTO_RD};
		repeat (4) @(posedge sysClk);
		reset <= 1'b0;

		// Everything zero out of reset
		@(negedge sysClk);
		checkMask("readEd", readEd, '0);
		@(posedge sysClk);
		foreach (csrList[i])
		begin
			csrRead(csrList[i], word);
			checkStatus($sformatf("csrRd(0x%h)", csrList[i]), word, '0);
		end

		// Scratch registers with offsets 4 and 5 unmapped
		for (int i = 0; i < lpRegOps; i++)
		begin
			ofs = int'(nextRand() >> 16) % 6;
			data = nextRand();
			if (data[20])
			begin
				busWrite(0, ofs, data);
				if (ofs < 4)
					regModel[ofs] = data;
			end
			else
				readAndCheck(0, ofs, (ofs < 4) ? regModel[ofs] : '0);
		end

		// Accumulator with mixed adds, clears and reads
		for (int i = 0; i < lpAccOps; i++)
		begin
			pick = int'(nextRand() >> 16) % 8;
			if (pick == 0)
			begin
				busWrite(1, 0, nextRand());
				accSum = '0;
				accCount = '0;
			end
			else if (pick <= 4)
			begin
				data = nextRand();
				busWrite(1, 1, data);
				accSum = accSum + data;
				accCount = accCount + 1;
			end
			else if (pick <= 6)
				readAndCheck(1, 0, accSum);
			else
				readAndCheck(1, 2, accCount);
		end
		readAndCheck(1, 0, accSum);
		readAndCheck(1, 2, accCount);

		// Unmapped slave 5 times out and the next command clears the flag
		busOp(makeBusAdrs(5, 0), '0, 32'h2);
		csrRead(csrPkg::CSR_STATUS, word);
		checkStatus("csrRd(CSR_STATUS)", word, expStatus(1'b1));
		data = nextRand();
		busWrite(0, 2, data);
		regModel[2] = data;
		csrRead(csrPkg::CSR_STATUS, word);
		checkStatus("csrRd(CSR_STATUS)", word, expStatus(1'b0));
		readAndCheck(0, 2, regModel[2]);

		// Second command in the busy cycle
		busWrite(1, 0, '0);
		data = nextRand();
		csrWrite(csrPkg::CSR_BUS_ADRS, makeBusAdrs(1, 1));
		csrWrite(csrPkg::CSR_BUS_WD, data);
		csrWrite(csrPkg::CSR_CMD, 32'h1);
		// An accepted repeat would add twice
		csrWrite(csrPkg::CSR_CMD, 32'h3);
		waitNotBusy();
		accSum = data;
		accCount = 1;
		readAndCheck(1, 0, accSum);
		readAndCheck(1, 2, accCount);

		// Plain register read-back
		data = nextRand();
		csrWrite(csrPkg::CSR_BUS_ADRS, data);
		csrRead(csrPkg::CSR_BUS_ADRS, word);
		checkStatus("csrRd(CSR_BUS_ADRS)", word, data);
		data = nextRand();
		csrWrite(csrPkg::CSR_BUS_WD, data);
		csrRead(csrPkg::CSR_BUS_WD, word);
		checkStatus("csrRd(CSR_BUS_WD)", word, data);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/microControllerBlock.sv */
`timescale 1ns/1ps
`default_nettype none

module microControllerBlock
(
	input wire sysClk,
	input wire reset,
	// Debug host side
	input wire csrPkg::csrData_t csrWd,
	input wire csrPkg::csrAdrs_t csrAdrs,
	input wire csrCke,
	output csrPkg::csrData_t csrRd,
	output busPkg::busData_t autoRd,
	output busPkg::slaveMask_t readEd
);

	// ----------------------------------------
	// Bus nets
	// ----------------------------------------

	// Master drive, seen by every slave
	busPkg::busData_t busWd;
	busPkg::busAdrs_t busAdrs;
	logic busWEd;
	// Per slave replies
	busPkg::busData_t slvRd0;
	busPkg::busData_t slvRd1;
	busPkg::slaveMask_t slvREd;
	// Capture back to control
	logic readDone;
	busPkg::slaveIdx_t capIdx;

	// Command sequencer and CSR space
	microControllerCsr csr_i (
		.sysClk (sysClk),
		.reset (reset),
		.csrWd (csrWd),
		.csrAdrs (csrAdrs),
		.csrCke (csrCke),
		.csrRd (csrRd),
		.busWd (busWd),
		.busAdrs (busAdrs),
		.busWEd (busWEd),
		.readDone (readDone),
		.capRd (autoRd),
		.capIdx (capIdx)
	);

	// Captured data doubles as the auto read result
	busReadCapture capture_i (
		.sysClk (sysClk),
		.reset (reset),
		.slvRd0 (slvRd0),
		.slvRd1 (slvRd1),
		.slvREd (slvREd),
		.readDone (readDone),
		.capRd (autoRd),
		.capIdx (capIdx),
		.readEd (readEd)
	);

	// ----------------------------------------
	// Slaves
	// ----------------------------------------
	regFileSlave #(
		.pSlaveIdx (3'd0)
	) regFile_i (
		.sysClk (sysClk),
		.reset (reset),
		.busWd (busWd),
		.busAdrs (busAdrs),
		.busWEd (busWEd),
		.slvRd (slvRd0),
		.slvREd (slvREd[0])
	);

	accumulatorSlave #(
		.pSlaveIdx (3'd1)
	) accumulator_i (
		.sysClk (sysClk),
		.reset (reset),
		.busWd (busWd),
		.busAdrs (busAdrs),
		.busWEd (busWEd),
		.slvRd (slvRd1),
		.slvREd (slvREd[1])
	);

endmodule

`default_nettype wire

/* src/accumulatorSlave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcbBus_defs.svh"

module accumulatorSlave #(
	parameter busPkg::slaveIdx_t pSlaveIdx = '0
)(
	input wire sysClk,
	input wire reset,
	input wire busPkg::busData_t busWd,
	input wire busPkg::busAdrs_t busAdrs,
	input wire busWEd,
	output busPkg::busData_t slvRd,
	output logic slvREd
);

	busPkg::busData_t sum;
	busPkg::busData_t count;
	logic [`MCB_SLAVE_LSB-1:0] regOfs;
	logic slaveHit;
	logic isRead;
	logic addStrobe;
	logic clearStrobe;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	always_comb
	begin
		slaveHit = busWEd && (busAdrs[`MCB_SLAVE_MSB:`MCB_SLAVE_LSB] == pSlaveIdx);
		isRead = busAdrs[`MCB_READ_CMD_BIT];
		regOfs = busAdrs[`MCB_SLAVE_LSB-1:0];
		// Register 1 adds, register 0 clears
		addStrobe = slaveHit && !isRead && (regOfs == 1);
		clearStrobe = slaveHit && !isRead && (regOfs == 0);
	end

	// Running sum wraps modulo 2^32
	always_ff @(posedge sysClk)
	begin
		if (reset || clearStrobe)
		begin
			sum <= '0;
			count <= '0;
		end
		else if (addStrobe)
		begin
			sum <= sum + busWd;
			count <= count + 1'b1;
		end
	end

	// Sum on offset 0, count on offset 2
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			slvREd <= 1'b0;
			slvRd <= '0;
		end
		else
		begin
			slvREd <= slaveHit && isRead;
			if (slaveHit && isRead && (regOfs == 0))
				slvRd <= sum;
			else if (slaveHit && isRead && (regOfs == 2))
				slvRd <= count;
			else
				slvRd <= '0;
		end
	end

	// Count never wraps on an add
	assert property (@(posedge sysClk) disable iff (reset)
		addStrobe |=> (count != '0));

endmodule

`default_nettype wire

/* src/regFileSlave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcbBus_defs.svh"

module regFileSlave #(
	parameter busPkg::slaveIdx_t pSlaveIdx = '0
)(
	input wire sysClk,
	input wire reset,
	input wire busPkg::busData_t busWd,
	input wire busPkg::busAdrs_t busAdrs,
	input wire busWEd,
	output busPkg::busData_t slvRd,
	output logic slvREd
);

	busPkg::busData_t regs [4];
	logic [`MCB_SLAVE_LSB-1:0] regOfs;
	logic slaveHit;
	logic isRead;
	logic ofsValid;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	always_comb
	begin
		slaveHit = busWEd && (busAdrs[`MCB_SLAVE_MSB:`MCB_SLAVE_LSB] == pSlaveIdx);
		isRead = busAdrs[`MCB_READ_CMD_BIT];
		regOfs = busAdrs[`MCB_SLAVE_LSB-1:0];
		// Only offsets 0 to 3 exist
		ofsValid = (regOfs < 4);
	end

	// Scratch registers
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end
		else if (slaveHit && !isRead && ofsValid)
			regs[regOfs[1:0]] <= busWd;
	end

	// Reply one cycle after the request, zero otherwise
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			slvREd <= 1'b0;
			slvRd <= '0;
		end
		else
		begin
			slvREd <= slaveHit && isRead;
			slvRd <= (slaveHit && isRead && ofsValid) ? regs[regOfs[1:0]] : '0;
		end
	end

endmodule

`default_nettype wire

/* src/busReadCapture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcbBus_defs.svh"

module busReadCapture
(
	input wire sysClk,
	input wire reset,
	// Slave replies
	input wire busPkg::busData_t slvRd0,
	input wire busPkg::busData_t slvRd1,
	input wire busPkg::slaveMask_t slvREd,
	// Captured result
	output logic readDone,
	output busPkg::busData_t capRd,
	output busPkg::slaveIdx_t capIdx,
	output busPkg::slaveMask_t readEd
);

	busPkg::busData_t mergedRd;
	busPkg::slaveIdx_t replyIdx;
	logic replyValid;

	// ----------------------------------------
	// Reply merge
	// ----------------------------------------

	// Idle slaves drive zero so a plain OR is enough
	always_comb
	begin
		mergedRd = slvRd0 | slvRd1;
		replyValid = |slvREd;
	end

	// One-hot mask to slave index
	always_comb
	begin
		replyIdx = '0;
		for (int i = 0; i < `MCB_SLAVE_NUM; i++)
		begin
			if (slvREd[i])
				replyIdx = busPkg::slaveIdx_t'(i);
		end
	end

	// ----------------------------------------
	// Capture registers
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			readDone <= 1'b0;
			capRd <= '0;
			capIdx <= '0;
			readEd <= '0;
		end
		else
		begin
			readDone <= replyValid;
			// Held until the next reply
			if (replyValid)
			begin
				capRd <= mergedRd;
				capIdx <= replyIdx;
				readEd <= slvREd;
			end
		end
	end

	// At most one slave answers at a time
	assert property (@(posedge sysClk) disable iff (reset) $onehot0(slvREd));

endmodule

`default_nettype wire

/* src/microControllerCsr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcbBus_defs.svh"

module microControllerCsr
(
	input wire sysClk,
	input wire reset,
	// Host strobe interface
	input wire csrPkg::csrData_t csrWd,
	input wire csrPkg::csrAdrs_t csrAdrs,
	input wire csrCke,
	output csrPkg::csrData_t csrRd,
	// Bus master outputs
	output busPkg::busData_t busWd,
	output busPkg::busAdrs_t busAdrs,
	output logic busWEd,
	// Reply from the capture block
	input wire readDone,
	input wire busPkg::busData_t capRd,
	input wire busPkg::slaveIdx_t capIdx
);

	// Counter wide enough to hold the timeout value
	localparam int lpCntBit = $clog2(`MCB_READ_TIMEOUT + 1);
	typedef logic [lpCntBit-1:0] timeoutCnt_t;

	csrPkg::ctrlState_t state;
	csrPkg::csrData_t adrsReg;
	csrPkg::csrData_t wdReg;
	csrPkg::csrData_t statusWord;
	busPkg::busAdrs_t issueAdrs;
	timeoutCnt_t timeoutCnt;
	logic timeoutErr;
	logic timeoutHit;
	logic busy;
	logic cmdWrite;
	logic cmdStart;
	logic cmdIsRead;

	// ----------------------------------------
	// Command decode
	// ----------------------------------------
	always_comb
	begin
		cmdWrite = csrCke && (csrAdrs == csrPkg::CSR_CMD);
		// Commands only taken while idle
		cmdStart = cmdWrite && (csrWd[0] || csrWd[1]) && (state == csrPkg::IDLE);
		// Write wins when both bits set
		cmdIsRead = !csrWd[0];
		busy = (state != csrPkg::IDLE);
		timeoutHit = (timeoutCnt == timeoutCnt_t'(`MCB_READ_TIMEOUT - 1));
		statusWord = {25'd0, capIdx, 2'b00, timeoutErr, busy};
	end

	// Address put on the bus, command bit forced by the request type
	always_comb
	begin
		issueAdrs = adrsReg[`MCB_BUS_ADRS_BIT-1:0];
		issueAdrs[`MCB_READ_CMD_BIT] = cmdIsRead;
	end

	// ----------------------------------------
	// Host writable registers
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			adrsReg <= '0;
			wdReg <= '0;
		end
		else if (csrCke)
		begin
			// Still taken while busy, bus side already latched
			case (csrAdrs)
				csrPkg::CSR_BUS_ADRS: adrsReg <= csrWd;
				csrPkg::CSR_BUS_WD: wdReg <= csrWd;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Bus sequencer
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state <= csrPkg::IDLE;
			busWEd <= 1'b0;
			busWd <= '0;
			busAdrs <= '0;
			timeoutCnt <= '0;
			timeoutErr <= 1'b0;
		end
		else
		begin
			// Strobe lasts one cycle
			busWEd <= 1'b0;
			case (state)
				csrPkg::IDLE:
				begin
					if (cmdStart)
					begin
						busWd <= wdReg;
						busAdrs <= issueAdrs;
						busWEd <= 1'b1;
						timeoutCnt <= '0;
						// Sticky error drops on the next command
						timeoutErr <= 1'b0;
						state <= cmdIsRead ? csrPkg::READ_WAIT : csrPkg::WRITE;
					end
				end
				// Slave takes the data in the issue cycle
				csrPkg::WRITE: state <= csrPkg::IDLE;
				csrPkg::READ_WAIT:
				begin
					if (readDone)
						state <= csrPkg::IDLE;
					else if (timeoutHit)
					begin
						// No slave answered, unmapped index most likely
						state <= csrPkg::IDLE;
						timeoutErr <= 1'b1;
					end
					else
						timeoutCnt <= timeoutCnt + 1'b1;
				end
				default: state <= csrPkg::IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Registered read-back
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
			csrRd <= '0;
		else
		begin
			case (csrAdrs)
				csrPkg::CSR_BUS_ADRS: csrRd <= adrsReg;
				csrPkg::CSR_BUS_WD: csrRd <= wdReg;
				csrPkg::CSR_STATUS: csrRd <= statusWord;
				csrPkg::CSR_AUTO_RD: csrRd <= capRd;
				// Command register reads as zero
				default: csrRd <= '0;
			endcase
		end
	end

	// Single-cycle request strobe
	assert property (@(posedge sysClk) disable iff (reset) busWEd |=> !busWEd);

	// Replies only come back for a read in flight
	assert property (@(posedge sysClk) disable iff (reset)
		readDone |-> (state == csrPkg::READ_WAIT));

endmodule

`default_nettype wire

/* src/csrPkg.sv */
`default_nettype none

package csrPkg;

	// ----------------------------------------
	// Host side types
	// ----------------------------------------

	typedef logic [7:0] csrAdrs_t;
	typedef logic [31:0] csrData_t;

	// ----------------------------------------
	// CSR map
	// ----------------------------------------

	// Target address, bit 15 overridden at issue
	localparam csrAdrs_t CSR_BUS_ADRS = 8'h00;
	localparam csrAdrs_t CSR_BUS_WD = 8'h04;
	// Bit 0 write, bit 1 read
	localparam csrAdrs_t CSR_CMD = 8'h08;
	// Busy, timeout, last slave
	localparam csrAdrs_t CSR_STATUS = 8'h0C;
	localparam csrAdrs_t CSR_AUTO_RD = 8'h10;

	// Control sequencer
	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		READ_WAIT
	} ctrlState_t;

endpackage

`default_nettype wire

/* src/busPkg.sv */
`default_nettype none

`include "mcbBus_defs.svh"

package busPkg;

	// ----------------------------------------
	// Slave bus types
	// ----------------------------------------

	// One data word on the bus
	typedef logic [31:0] busData_t;

	// Command bit, slave select and register offset together
	typedef logic [`MCB_BUS_ADRS_BIT-1:0] busAdrs_t;

	// Read-enable lines, one per slave
	typedef logic [`MCB_SLAVE_NUM-1:0] slaveMask_t;

	// Wide enough for 8 slaves
	typedef logic [2:0] slaveIdx_t;

endpackage

`default_nettype wire

/* src/mcbBus_defs.svh */
`ifndef MCB_BUS_DEFS_SVH
`define MCB_BUS_DEFS_SVH

// ----------------------------------------
// Slave bus geometry
// ----------------------------------------

// Slaves hung on the bus, up to 8
`define MCB_SLAVE_NUM 2

// Address port width, command bit included
`define MCB_BUS_ADRS_BIT 16

// Set on the address port for a read request
`define MCB_READ_CMD_BIT 15

// Slave select field inside the address
`define MCB_SLAVE_MSB 14
`define MCB_SLAVE_LSB 12

// Cycles a read may wait for its reply
`define MCB_READ_TIMEOUT 8

`endif
